// File: rv_int_core.f
common/rv_pkg.sv
decode/rv_decoder.sv
rtl/rv_regfile.sv
execute/rv_alu.sv
execute/rv_branch_unit.sv
rtl/rv_result.sv
rtl/rv_int_core.sv
sim/rv_int_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_int_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f rv_int_core.f --top-module rv_int_core_tb -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vrv_int_core_tb 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
  exit 0
fi
echo "Pass message not found"
exit 1

// File: sim/rv_int_core_tb.sv
`timescale 1ns/10ps

module rv_int_core_tb import rv_pkg::*; ();

  localparam int num_instr   = 2000;
  localparam int cycle_limit = num_instr * 3 + 100;

  // One retire slot, pushed by the driver and popped by the checker
  typedef struct packed {
    logic        strobe;
    logic        wb;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        redir;
    logic [31:0] target;
    logic        unsup;
    logic        illeg;
  } retire_t;

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        wb_valid;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        unsupported;
  logic        illegal;

  logic [31:0] model_regs [32];
  retire_t     exp_q [$];
  int          cycles = 0;
  int          strobes_checked = 0;

  rv_int_core i_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .wb_valid    (wb_valid),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .unsupported (unsupported),
    .illegal     (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("mismatch %s expected %h actual %h", name, exp_val, act_val);
      $display("STATUS: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // RV32I integer op on two operands, alt selects sub and sra
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'd0);
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      funct_beq:  return a == b;
      funct_bne:  return a != b;
      funct_blt:  return $signed(a) < $signed(b);
      funct_bge:  return !($signed(a) < $signed(b));
      funct_bltu: return a < b;
      default:    return !(a < b);
    endcase
  endfunction

  // Mostly x0..x7 so that dependent pairs show up often
  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    r = $urandom;
    return (r[1:0] == 2'b00) ? r[6:2] : {2'b00, r[4:2]};
  endfunction

  task automatic write_rd(inout retire_t e, input logic [4:0] rd, input logic [31:0] val);
    if (rd != 5'd0) begin
      e.wb   = 1'b1;
      e.rd   = rd;
      e.data = val;
      model_regs[rd] = val;
    end
  endtask

  task automatic build_instr(input logic [31:0] ipc, output logic [31:0] ins,
                             output retire_t e);
    int unsigned cls;
    logic [31:0] rnd;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [11:0] ifield;
    cls = $urandom % 100;
    rnd = $urandom;
    rd  = pick_reg();
    rs1 = pick_reg();
    rs2 = ($urandom % 4 == 0) ? rs1 : pick_reg();
    f3  = 3'($urandom % 8);
    alt = 1'b0;
    a   = model_regs[rs1];
    b   = model_regs[rs2];
    e   = '0;
    e.strobe = 1'b1;
    if (cls < 35) begin
      if (f3 == 3'd0 || f3 == 3'd5)
        alt = 1'($urandom % 2);
      ins = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, opcode_register};
      write_rd(e, rd, alu_ref(f3, alt, a, b));
    end else if (cls < 70) begin
      if (f3 == 3'd1 || f3 == 3'd5) begin
        alt    = (f3 == 3'd5) ? 1'($urandom % 2) : 1'b0;
        ifield = {alt ? 7'b0100000 : 7'b0000000, rnd[4:0]};
        imm    = {27'd0, rnd[4:0]};
      end else begin
        ifield = rnd[11:0];
        imm    = {{20{rnd[11]}}, rnd[11:0]};
      end
      ins = {ifield, rs1, f3, rd, opcode_immediate};
      write_rd(e, rd, alu_ref(f3, alt, a, imm));
    end else if (cls < 75) begin
      ins = {rnd[31:12], rd, opcode_lui};
      write_rd(e, rd, {rnd[31:12], 12'd0});
    end else if (cls < 80) begin
      ins = {rnd[31:12], rd, opcode_auipc};
      write_rd(e, rd, ipc + {rnd[31:12], 12'd0});
    end else if (cls < 84) begin
      ins      = {rnd[20], rnd[10:1], rnd[11], rnd[19:12], rd, opcode_jal};
      e.redir  = 1'b1;
      e.target = ipc + {{11{rnd[20]}}, rnd[20:1], 1'b0};
      write_rd(e, rd, ipc + 32'd4);
    end else if (cls < 88) begin
      ins      = {rnd[11:0], rs1, 3'b000, rd, opcode_jalr};
      e.redir  = 1'b1;
      e.target = (a + {{20{rnd[11]}}, rnd[11:0]}) & 32'hfffffffe;
      write_rd(e, rd, ipc + 32'd4);
    end else if (cls < 95) begin
      case ($urandom % 6)
        0:       f3 = funct_beq;
        1:       f3 = funct_bne;
        2:       f3 = funct_blt;
        3:       f3 = funct_bge;
        4:       f3 = funct_bltu;
        default: f3 = funct_bgeu;
      endcase
      ins      = {rnd[12], rnd[10:5], rs2, rs1, f3, rnd[4:1], rnd[11], opcode_branch};
      e.redir  = branch_taken(f3, a, b);
      e.target = ipc + {{19{rnd[12]}}, rnd[12:1], 1'b0};
    end else if (cls < 96) begin
      ins = nop_instr;
    end else if (cls < 98) begin
      e.unsup = 1'b1;
      case ($urandom % 6)
        0:       ins = {rnd[11:0], rs1, 3'b010, rd, opcode_load};
        1:       ins = {rnd[11:5], rs2, rs1, 3'b010, rnd[4:0], opcode_store};
        2:       ins = {7'b0000001, rs2, rs1, f3, rd, opcode_register};
        3:       ins = 32'h0ff0000f;                                // fence
        4:       ins = {12'h300, rs1, 3'b001, rd, opcode_system};   // csrrw
        default: ins = 32'h00000073;                                // ecall
      endcase
    end else begin
      e.illeg = 1'b1;
      case ($urandom % 5)
        0:       ins = {rnd[31:7], 7'b1111111};
        1:       ins = {rnd[12], rnd[10:5], rs2, rs1, 3'b010, rnd[4:1], rnd[11], opcode_branch};
        2:       ins = {7'b0100000, rs2, rs1, 3'b001, rd, opcode_register};
        3:       ins = {rnd[11:0], rs1, 3'b001, rd, opcode_jalr};
        default: ins = {7'b0100000, rnd[4:0], rs1, 3'b001, rd, opcode_immediate};
      endcase
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  // Outputs settle after the edge, so compare at the falling edge
  always @(negedge clk) begin
    retire_t e;
    if (exp_q.size() > 1) begin
      e = exp_q.pop_front();
      check("wb_valid", {31'd0, e.wb}, {31'd0, wb_valid});
      if (e.wb) begin
        check("wb_addr", {27'd0, e.rd}, {27'd0, wb_addr});
        check("wb_data", e.data, wb_data);
      end
      check("redirect", {31'd0, e.redir}, {31'd0, redirect});
      if (e.redir)
        check("redirect_pc", e.target, redirect_pc);
      check("unsupported", {31'd0, e.unsup}, {31'd0, unsupported});
      check("illegal", {31'd0, e.illeg}, {31'd0, illegal});
      if (e.strobe)
        strobes_checked = strobes_checked + 1;
    end
  end

  initial begin
    retire_t     e;
    logic [31:0] ins;
    logic [31:0] ipc;
    int unsigned seed;
    seed        = $urandom(7);
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = nop_instr;
    pc          = 32'd0;
    for (int i = 0; i < 32; i++)
      model_regs[i] = 32'd0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    exp_q.push_back('0); // First cycle out of reset is idle

    for (int n = 0; n < num_instr; n++) begin
      if ($urandom % 3 == 0) begin
        @(posedge clk);
        instr_valid <= 1'b0;
        exp_q.push_back('0);
      end
      @(posedge clk);
      ipc = $urandom & 32'hfffffffc;
      build_instr(ipc, ins, e);
      instr_valid <= 1'b1;
      instr       <= ins;
      pc          <= ipc;
      exp_q.push_back(e);
    end

    repeat (3) begin // Drain the last retire
      @(posedge clk);
      instr_valid <= 1'b0;
      exp_q.push_back('0);
    end
    @(posedge clk);

    if (strobes_checked == num_instr) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("error: only %0d of %0d instructions were checked", strobes_checked, num_instr);
      $display("STATUS: FAIL");
      $fatal(1, "incomplete run");
    end
  end

endmodule

// File: rtl/rv_int_core.sv
`timescale 1ns/10ps

module rv_int_core import rv_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            instr_valid,
  input  logic [xlen-1:0] instr,
  input  logic [xlen-1:0] pc,
  output logic            wb_valid,
  output logic [4:0]      wb_addr,
  output logic [xlen-1:0] wb_data,
  output logic            redirect,
  output logic [xlen-1:0] redirect_pc,
  output logic            unsupported,
  output logic            illegal
);

  logic [xlen-1:0] imm;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [4:0]      rd_addr;
  logic            wren;
  alu_op_type      alu_op;
  bcu_op_type      bcu_op;
  src_a_type       src_a;
  logic            use_imm;
  wb_sel_type      wb_sel;
  logic            jal;
  logic            jalr;
  logic            dec_unsupported;
  logic            dec_valid;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_result;
  logic            taken;
  logic [xlen-1:0] target;
  logic            rf_we;
  logic [4:0]      rf_waddr;
  logic [xlen-1:0] rf_wdata;

  rv_decoder i_decoder (
    .instr       (instr),
    .imm         (imm),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd_addr     (rd_addr),
    .wren        (wren),
    .alu_op      (alu_op),
    .bcu_op      (bcu_op),
    .src_a       (src_a),
    .use_imm     (use_imm),
    .wb_sel      (wb_sel),
    .jal         (jal),
    .jalr        (jalr),
    .unsupported (dec_unsupported),
    .valid       (dec_valid)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu i_alu (
    .alu_op     (alu_op),
    .src_a      (src_a),
    .use_imm    (use_imm),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .pc         (pc),
    .alu_result (alu_result)
  );

  rv_branch_unit i_branch_unit (
    .bcu_op   (bcu_op),
    .jal      (jal),
    .jalr     (jalr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .pc       (pc),
    .taken    (taken),
    .target   (target)
  );

  rv_result i_result (
    .clk             (clk),
    .arst_n          (arst_n),
    .instr_valid     (instr_valid),
    .valid           (dec_valid),
    .unsupported     (dec_unsupported),
    .wren            (wren),
    .rd_addr         (rd_addr),
    .wb_sel          (wb_sel),
    .alu_result      (alu_result),
    .pc              (pc),
    .taken           (taken),
    .target          (target),
    .rf_we           (rf_we),
    .rf_waddr        (rf_waddr),
    .rf_wdata        (rf_wdata),
    .wb_valid        (wb_valid),
    .wb_addr         (wb_addr),
    .wb_data         (wb_data),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .illegal         (illegal),
    .unsupported_out (unsupported)
  );

endmodule

// File: rtl/rv_result.sv
`timescale 1ns/10ps

module rv_result import rv_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            instr_valid,
  input  logic            valid,
  input  logic            unsupported,
  input  logic            wren,
  input  logic [4:0]      rd_addr,
  input  wb_sel_type      wb_sel,
  input  logic [xlen-1:0] alu_result,
  input  logic [xlen-1:0] pc,
  input  logic            taken,
  input  logic [xlen-1:0] target,
  output logic            rf_we,
  output logic [4:0]      rf_waddr,
  output logic [xlen-1:0] rf_wdata,
  output logic            wb_valid,
  output logic [4:0]      wb_addr,
  output logic [xlen-1:0] wb_data,
  output logic            redirect,
  output logic [xlen-1:0] redirect_pc,
  output logic            illegal,
  output logic            unsupported_out
);

  logic exec_ok;

  // Recognised and handled by this slice
  assign exec_ok = instr_valid && valid && !unsupported;

  // Write lands at the strobe edge so the next instruction sees it
  assign rf_we    = exec_ok && wren;
  assign rf_waddr = rd_addr;
  assign rf_wdata = (wb_sel == wb_link) ? pc + 32'd4 : alu_result;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid        <= 1'b0;
      redirect        <= 1'b0;
      illegal         <= 1'b0;
      unsupported_out <= 1'b0;
    end else begin
      wb_valid        <= rf_we;
      redirect        <= exec_ok && taken;
      illegal         <= instr_valid && !valid;
      unsupported_out <= instr_valid && valid && unsupported;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      wb_addr     <= rf_waddr;
      wb_data     <= rf_wdata;
      redirect_pc <= target;
    end
  end

endmodule

// File: execute/rv_branch_unit.sv
`timescale 1ns/10ps

module rv_branch_unit import rv_pkg::*; (
  input  bcu_op_type      bcu_op,
  input  logic            jal,
  input  logic            jalr,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] pc,
  output logic            taken,
  output logic [xlen-1:0] target
);

  logic            eq;
  logic            lt;
  logic            ltu;
  logic [xlen-1:0] jalr_sum;

  assign eq  = (rs1_data == rs2_data);
  assign lt  = $signed(rs1_data) < $signed(rs2_data);
  assign ltu = rs1_data < rs2_data;

  always_comb begin
    case (bcu_op)
      bcu_beq:  taken = eq;
      bcu_bne:  taken = !eq;
      bcu_blt:  taken = lt;
      bcu_bge:  taken = !lt;
      bcu_bltu: taken = ltu;
      bcu_bgeu: taken = !ltu;
      default:  taken = jal || jalr; // Jumps always redirect
    endcase
  end

  assign jalr_sum = rs1_data + imm;
  assign target   = jalr ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;

endmodule

// File: execute/rv_alu.sv
`timescale 1ns/10ps

module rv_alu import rv_pkg::*; (
  input  alu_op_type      alu_op,
  input  src_a_type       src_a,
  input  logic            use_imm,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] pc,
  output logic [xlen-1:0] alu_result
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;

  assign op_a  = (src_a == src_a_pc) ? pc : rs1_data;
  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << shamt;
      alu_slt:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_result = {31'd0, op_a < op_b};
      alu_xor:    alu_result = op_a ^ op_b;
      alu_srl:    alu_result = op_a >> shamt;
      alu_sra:    alu_result = $unsigned($signed(op_a) >>> shamt);
      alu_or:     alu_result = op_a | op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

endmodule

// File: rtl/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  input  logic            we,
  input  logic [4:0]      waddr,
  input  logic [xlen-1:0] wdata,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata; // x0 never written, stays zero
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

// File: decode/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder import rv_pkg::*; (
  input  logic [xlen-1:0] instr,
  output logic [xlen-1:0] imm,
  output logic [4:0]      rs1_addr,
  output logic [4:0]      rs2_addr,
  output logic [4:0]      rd_addr,
  output logic            wren,
  output alu_op_type      alu_op,
  output bcu_op_type      bcu_op,
  output src_a_type       src_a,
  output logic            use_imm,
  output wb_sel_type      wb_sel,
  output logic            jal,
  output logic            jalr,
  output logic            unsupported,
  output logic            valid
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            rd_nz;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rd_addr  = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign rd_nz    = |instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    imm         = '0;
    wren        = 1'b0;
    alu_op      = alu_add;
    bcu_op      = bcu_none;
    src_a       = src_a_reg;
    use_imm     = 1'b0;
    wb_sel      = wb_alu;
    jal         = 1'b0;
    jalr        = 1'b0;
    unsupported = 1'b0;
    valid       = 1'b1;

    case (opcode)
      opcode_lui: begin
        imm     = imm_u;
        wren    = rd_nz;
        use_imm = 1'b1;
        alu_op  = alu_pass_b;
      end
      opcode_auipc: begin
        imm     = imm_u;
        wren    = rd_nz;
        use_imm = 1'b1;
        src_a   = src_a_pc; // pc + imm through the adder
      end
      opcode_jal: begin
        imm    = imm_j;
        wren   = rd_nz;
        wb_sel = wb_link;
        jal    = 1'b1;
      end
      opcode_jalr: begin
        imm    = imm_i;
        wren   = rd_nz;
        wb_sel = wb_link;
        jalr   = 1'b1;
        valid  = (funct3 == 3'b000);
      end
      opcode_branch: begin
        imm = imm_b;
        case (funct3)
          funct_beq:  bcu_op = bcu_beq;
          funct_bne:  bcu_op = bcu_bne;
          funct_blt:  bcu_op = bcu_blt;
          funct_bge:  bcu_op = bcu_bge;
          funct_bltu: bcu_op = bcu_bltu;
          funct_bgeu: bcu_op = bcu_bgeu;
          default:    valid = 1'b0;
        endcase
      end
      opcode_load: begin
        imm         = imm_i;
        unsupported = 1'b1;
        // lb lh lw lbu lhu
        valid = (funct3 == 3'd0) || (funct3 == 3'd1) || (funct3 == 3'd2) ||
                (funct3 == 3'd4) || (funct3 == 3'd5);
      end
      opcode_store: begin
        imm         = imm_s;
        unsupported = 1'b1;
        valid       = (funct3 <= 3'd2); // sb sh sw
      end
      opcode_immediate: begin
        imm     = imm_i;
        wren    = rd_nz;
        use_imm = 1'b1;
        case (funct3)
          funct_add:  alu_op = alu_add;
          funct_slt:  alu_op = alu_slt;
          funct_sltu: alu_op = alu_sltu;
          funct_xor:  alu_op = alu_xor;
          funct_or:   alu_op = alu_or;
          funct_and:  alu_op = alu_and;
          funct_sll: begin
            alu_op = alu_sll;
            valid  = (funct7 == 7'b0000000);
          end
          default: begin // srli / srai share funct3
            alu_op = (funct7 == 7'b0100000) ? alu_sra : alu_srl;
            valid  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      opcode_register: begin
        wren = rd_nz;
        if (funct7 == 7'b0000000) begin
          case (funct3)
            funct_add:  alu_op = alu_add;
            funct_sll:  alu_op = alu_sll;
            funct_slt:  alu_op = alu_slt;
            funct_sltu: alu_op = alu_sltu;
            funct_xor:  alu_op = alu_xor;
            funct_srl:  alu_op = alu_srl;
            funct_or:   alu_op = alu_or;
            default:    alu_op = alu_and;
          endcase
        end else if (funct7 == 7'b0100000) begin
          case (funct3)
            funct_add: alu_op = alu_sub;
            funct_srl: alu_op = alu_sra;
            default:   valid = 1'b0;
          endcase
        end else if (funct7 == 7'b0000001) begin
          unsupported = 1'b1; // M extension, all eight funct3 codes
        end else begin
          valid = 1'b0;
        end
      end
      opcode_fence: begin
        unsupported = 1'b1;
        valid       = (funct3 == 3'd0) || (funct3 == 3'd1); // fence, fence.i
      end
      opcode_system: begin
        unsupported = 1'b1;
        if (funct3 == 3'd0) begin
          // ecall, ebreak, wfi, mret
          valid = (instr[31:20] == 12'h000) || (instr[31:20] == 12'h001) ||
                  (instr[31:20] == 12'h105) || (instr[31:20] == 12'h302);
        end else begin
          valid = (funct3 != 3'd4); // CSR access
        end
      end
      default: valid = 1'b0;
    endcase

    if (unsupported || !valid)
      wren = 1'b0;
  end

endmodule

// File: common/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  // Major opcodes
  localparam logic [6:0] opcode_lui       = 7'b0110111;
  localparam logic [6:0] opcode_auipc     = 7'b0010111;
  localparam logic [6:0] opcode_jal       = 7'b1101111;
  localparam logic [6:0] opcode_jalr      = 7'b1100111;
  localparam logic [6:0] opcode_branch    = 7'b1100011;
  localparam logic [6:0] opcode_load      = 7'b0000011;
  localparam logic [6:0] opcode_store     = 7'b0100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register  = 7'b0110011;
  localparam logic [6:0] opcode_fence     = 7'b0001111;
  localparam logic [6:0] opcode_system    = 7'b1110011;

  // Branch funct3
  localparam logic [2:0] funct_beq  = 3'b000;
  localparam logic [2:0] funct_bne  = 3'b001;
  localparam logic [2:0] funct_blt  = 3'b100;
  localparam logic [2:0] funct_bge  = 3'b101;
  localparam logic [2:0] funct_bltu = 3'b110;
  localparam logic [2:0] funct_bgeu = 3'b111;

  // ALU funct3, shared by register and immediate forms
  localparam logic [2:0] funct_add  = 3'b000;
  localparam logic [2:0] funct_sll  = 3'b001;
  localparam logic [2:0] funct_slt  = 3'b010;
  localparam logic [2:0] funct_sltu = 3'b011;
  localparam logic [2:0] funct_xor  = 3'b100;
  localparam logic [2:0] funct_srl  = 3'b101;
  localparam logic [2:0] funct_or   = 3'b110;
  localparam logic [2:0] funct_and  = 3'b111;

  localparam logic [31:0] nop_instr = 32'h00000013; // addi x0,x0,0

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b // lui
  } alu_op_type;

  typedef enum logic [2:0] {
    bcu_none,
    bcu_beq,
    bcu_bne,
    bcu_blt,
    bcu_bge,
    bcu_bltu,
    bcu_bgeu
  } bcu_op_type;

  typedef enum logic [0:0] {
    src_a_reg,
    src_a_pc
  } src_a_type;

  typedef enum logic [1:0] {
    wb_alu,
    wb_link
  } wb_sel_type;

endpackage
